// File: logic/ctrlPkg.sv
package ctrlPkg;

    typedef logic [31:0] instr_t;            // full instruction word
    typedef logic [5:0]  opcode_t;           // instr[31:26]
    typedef logic [5:0]  funct_t;            // instr[5:0]

    typedef enum logic [2:0] {
        pcNext   = 3'd0,                     // PC+4
        pcBranch = 3'd1,
        pcJump   = 3'd2,
        pcReg    = 3'd3,                     // target from rs
        pcIrq    = 3'd4,
        pcExcept = 3'd5
    } pcSrc_t;

    typedef enum logic [1:0] {
        dstRd = 2'd0,
        dstRt = 2'd1,
        dstRa = 2'd2,                        // $31
        dstXp = 2'd3                         // $26, trap return address
    } regDst_t;

    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbMem  = 2'd1,
        wbLink = 2'd2,                       // PC+4
        wbIrq  = 2'd3
    } memToReg_t;

    typedef enum logic [5:0] {
        aluAdd = 6'b000000,
        aluSub = 6'b000001,
        aluAnd = 6'b011000,
        aluOr  = 6'b011110,
        aluXor = 6'b010110,
        aluNor = 6'b010001,
        aluSll = 6'b100000,
        aluSrl = 6'b100001,
        aluSra = 6'b100011,
        aluLt  = 6'b110101,
        aluEq  = 6'b110011,
        aluNe  = 6'b110001,
        aluLez = 6'b111101,
        aluGtz = 6'b111111,
        aluLtz = 6'b111011
    } aluFun_t;

    typedef struct packed {
        pcSrc_t    pcSrc;
        regDst_t   regDst;
        logic      regWr;
        logic      aluSrc1;                  // 1 selects shamt
        logic      aluSrc2;                  // 1 selects immediate
        aluFun_t   aluFun;
        logic      sign;
        logic      memWr;
        logic      memRd;
        memToReg_t memToReg;
        logic      extOp;                    // 1 sign-extends the immediate
        logic      luOp;
    } ctrlWord_t;

    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_SLTIU = 6'b001011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_BLEZ  = 6'b000110;
    localparam opcode_t OP_BGTZ  = 6'b000111;
    localparam opcode_t OP_BLTZ  = 6'b000001;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;

    // R-type funct codes
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;

    // PC+4, no register or memory write
    localparam ctrlWord_t CTRL_BUBBLE = '0;

endpackage

// File: logic/functDecoder.sv
module functDecoder (
    input  ctrlPkg::funct_t    funct,
    output ctrlPkg::ctrlWord_t rCtrl,
    output logic               rValid
);

    always_comb begin
        rCtrl  = ctrlPkg::CTRL_BUBBLE;       // dstRd, wbAlu, PC+4 by default
        rValid = 1'b1;
        case (funct)
            ctrlPkg::FN_ADD: begin
                rCtrl.aluFun = ctrlPkg::aluAdd;
                rCtrl.sign   = 1'b1;
            end
            ctrlPkg::FN_ADDU: rCtrl.aluFun = ctrlPkg::aluAdd;
            ctrlPkg::FN_SUB: begin
                rCtrl.aluFun = ctrlPkg::aluSub;
                rCtrl.sign   = 1'b1;
            end
            ctrlPkg::FN_SUBU: rCtrl.aluFun = ctrlPkg::aluSub;
            ctrlPkg::FN_AND:  rCtrl.aluFun = ctrlPkg::aluAnd;
            ctrlPkg::FN_OR:   rCtrl.aluFun = ctrlPkg::aluOr;
            ctrlPkg::FN_XOR:  rCtrl.aluFun = ctrlPkg::aluXor;
            ctrlPkg::FN_NOR:  rCtrl.aluFun = ctrlPkg::aluNor;
            ctrlPkg::FN_SLL: begin
                rCtrl.aluSrc1 = 1'b1;        // shamt
                rCtrl.aluFun  = ctrlPkg::aluSll;
            end
            ctrlPkg::FN_SRL: begin
                rCtrl.aluSrc1 = 1'b1;
                rCtrl.aluFun  = ctrlPkg::aluSrl;
            end
            ctrlPkg::FN_SRA: begin
                rCtrl.aluSrc1 = 1'b1;
                rCtrl.aluFun  = ctrlPkg::aluSra;
            end
            ctrlPkg::FN_SLT: begin
                rCtrl.aluFun = ctrlPkg::aluLt;
                rCtrl.sign   = 1'b1;
            end
            ctrlPkg::FN_JR: rCtrl.pcSrc = ctrlPkg::pcReg;
            ctrlPkg::FN_JALR: begin
                rCtrl.pcSrc    = ctrlPkg::pcReg;
                rCtrl.memToReg = ctrlPkg::wbLink;   // return address into rd
            end
            default: rValid = 1'b0;
        endcase

        // every defined funct but jr writes rd
        rCtrl.regWr = rValid && (funct != ctrlPkg::FN_JR);
    end

endmodule

// File: logic/opcodeDecoder.sv
module opcodeDecoder (
    input  ctrlPkg::opcode_t   opCode,
    input  ctrlPkg::ctrlWord_t rCtrl,
    input  logic               rValid,
    output ctrlPkg::ctrlWord_t decCtrl,
    output logic               decValid
);

    // ALU op on rs and the immediate, result into rt
    function automatic ctrlPkg::ctrlWord_t immOp(
        input ctrlPkg::aluFun_t fun,
        input logic             sgn,
        input logic             ext
    );
        ctrlPkg::ctrlWord_t w;
        w         = ctrlPkg::CTRL_BUBBLE;
        w.regDst  = ctrlPkg::dstRt;
        w.regWr   = 1'b1;
        w.aluSrc2 = 1'b1;
        w.aluFun  = fun;
        w.sign    = sgn;
        w.extOp   = ext;
        return w;
    endfunction

    // compare on rs/rt, sign-extended offset
    function automatic ctrlPkg::ctrlWord_t branchOp(input ctrlPkg::aluFun_t fun);
        ctrlPkg::ctrlWord_t w;
        w        = ctrlPkg::CTRL_BUBBLE;
        w.pcSrc  = ctrlPkg::pcBranch;
        w.aluFun = fun;
        w.extOp  = 1'b1;
        return w;
    endfunction

    always_comb begin
        decCtrl  = ctrlPkg::CTRL_BUBBLE;
        decValid = 1'b1;
        case (opCode)
            ctrlPkg::OP_RTYPE: begin
                decCtrl  = rCtrl;            // funct decides
                decValid = rValid;
            end
            ctrlPkg::OP_LW: begin
                decCtrl          = immOp(ctrlPkg::aluAdd, 1'b0, 1'b1);
                decCtrl.memRd    = 1'b1;
                decCtrl.memToReg = ctrlPkg::wbMem;
            end
            ctrlPkg::OP_SW: begin
                decCtrl        = immOp(ctrlPkg::aluAdd, 1'b0, 1'b1);
                decCtrl.regWr  = 1'b0;       // store has no register result
                decCtrl.regDst = ctrlPkg::dstRd;
                decCtrl.memWr  = 1'b1;
            end
            ctrlPkg::OP_LUI: begin
                decCtrl      = immOp(ctrlPkg::aluAdd, 1'b0, 1'b0);
                decCtrl.luOp = 1'b1;
            end
            ctrlPkg::OP_ADDI:  decCtrl = immOp(ctrlPkg::aluAdd, 1'b1, 1'b1);
            ctrlPkg::OP_ADDIU: decCtrl = immOp(ctrlPkg::aluAdd, 1'b0, 1'b1);
            ctrlPkg::OP_ANDI:  decCtrl = immOp(ctrlPkg::aluAnd, 1'b0, 1'b0);
            ctrlPkg::OP_SLTI:  decCtrl = immOp(ctrlPkg::aluLt, 1'b1, 1'b1);
            ctrlPkg::OP_SLTIU: decCtrl = immOp(ctrlPkg::aluLt, 1'b0, 1'b1);
            ctrlPkg::OP_BEQ:   decCtrl = branchOp(ctrlPkg::aluEq);
            ctrlPkg::OP_BNE:   decCtrl = branchOp(ctrlPkg::aluNe);
            ctrlPkg::OP_BLEZ:  decCtrl = branchOp(ctrlPkg::aluLez);
            ctrlPkg::OP_BGTZ:  decCtrl = branchOp(ctrlPkg::aluGtz);
            ctrlPkg::OP_BLTZ:  decCtrl = branchOp(ctrlPkg::aluLtz);
            ctrlPkg::OP_J:     decCtrl.pcSrc = ctrlPkg::pcJump;
            ctrlPkg::OP_JAL: begin
                decCtrl.pcSrc    = ctrlPkg::pcJump;
                decCtrl.regDst   = ctrlPkg::dstRa;
                decCtrl.regWr    = 1'b1;
                decCtrl.memToReg = ctrlPkg::wbLink;
            end
            default: decValid = 1'b0;        // undefined opcode
        endcase
    end

endmodule

// File: logic/trapArbiter.sv
module trapArbiter (
    input  ctrlPkg::ctrlWord_t decCtrl,
    input  logic               decValid,
    input  logic               irq,
    input  logic               pc31,
    output ctrlPkg::ctrlWord_t nextCtrl
);

    logic               userIrq;
    ctrlPkg::ctrlWord_t trapWord;

    assign userIrq = !pc31 && irq;           // kernel state masks irq

    // interrupt and exception share dstXp, differ in vector and write-back
    always_comb begin
        trapWord        = ctrlPkg::CTRL_BUBBLE;
        trapWord.regWr  = 1'b1;
        trapWord.regDst = ctrlPkg::dstXp;
        if (userIrq) begin
            trapWord.pcSrc    = ctrlPkg::pcIrq;
            trapWord.memToReg = ctrlPkg::wbIrq;
        end else begin
            trapWord.pcSrc    = ctrlPkg::pcExcept;
            trapWord.memToReg = ctrlPkg::wbLink;
        end
    end

    always_comb begin
        if (userIrq) begin
            nextCtrl = trapWord;
        end else if (!decValid) begin
            nextCtrl = pc31 ? ctrlPkg::CTRL_BUBBLE : trapWord;  // kernel gets a bubble
        end else begin
            nextCtrl = decCtrl;
        end
    end

endmodule

// File: logic/controlUnit.sv
module controlUnit (
    input  logic               clk,
    input  logic               rst,
    input  ctrlPkg::instr_t    instr,
    input  logic               irq,
    input  logic               pc31,
    output ctrlPkg::ctrlWord_t ctrl
);

    ctrlPkg::opcode_t   opCode;
    ctrlPkg::funct_t    funct;
    ctrlPkg::ctrlWord_t rCtrl;
    ctrlPkg::ctrlWord_t decCtrl;
    ctrlPkg::ctrlWord_t nextCtrl;
    logic               rValid;
    logic               decValid;

    assign opCode = instr[31:26];
    assign funct  = instr[5:0];

    functDecoder functDec (
        .funct  (funct),
        .rCtrl  (rCtrl),
        .rValid (rValid)
    );

    opcodeDecoder opDec (
        .opCode   (opCode),
        .rCtrl    (rCtrl),
        .rValid   (rValid),
        .decCtrl  (decCtrl),
        .decValid (decValid)
    );

    trapArbiter trapArb (
        .decCtrl  (decCtrl),
        .decValid (decValid),
        .irq      (irq),
        .pc31     (pc31),
        .nextCtrl (nextCtrl)
    );

    // decode-to-execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= ctrlPkg::CTRL_BUBBLE;
        end else begin
            ctrl <= nextCtrl;
        end
    end

endmodule

// File: sim/controlUnit_assertions.sv
module controlUnitAssertions (
    input logic               clk,
    input logic               rst,
    input logic               irq,
    input logic               pc31,
    input ctrlPkg::ctrlWord_t ctrl
);

    int failCount = 0;                       // summed into the final error count

    resetBubble: assert property (@(posedge clk) rst |=> ctrl == ctrlPkg::CTRL_BUBBLE)
        else begin
            $error("ctrl is not a bubble in the cycle after reset");
            failCount++;
        end

    // a load and a store never share one slot
    memExclusive: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.memWr && ctrl.memRd))
        else begin
            $error("memWr and memRd are both set");
            failCount++;
        end

    irqSource: assert property (@(posedge clk) disable iff (rst)
        ctrl.pcSrc == ctrlPkg::pcIrq |-> $past(irq && !pc31))
        else begin
            $error("interrupt word without a user-state irq on the previous edge");
            failCount++;
        end

endmodule

bind controlUnit controlUnitAssertions checks (
    .clk  (clk),
    .rst  (rst),
    .irq  (irq),
    .pc31 (pc31),
    .ctrl (ctrl)
);

// File: sim/controlUnitTb.sv
module controlUnitTb;

    localparam int MAX_LINES = 200;          // read bound for the vector file
    localparam int MAX_GAP   = 3;            // idle cycles between groups

    typedef struct packed {
        ctrlPkg::instr_t    instr;
        logic               irq;
        logic               pc31;
        ctrlPkg::ctrlWord_t expCtrl;
        logic               groupEnd;        // idle cycles may follow
    } vector_t;

    logic               clk;
    logic               rst;
    ctrlPkg::instr_t    instr;
    logic               irq;
    logic               pc31;
    ctrlPkg::ctrlWord_t ctrl;

    vector_t vectors[$];
    vector_t pending;                        // driven last cycle, due now
    logic    pendValid;
    int      pendIdx;
    int      errorCount;

    controlUnit DUT (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .irq   (irq),
        .pc31  (pc31),
        .ctrl  (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic loadVectors();
        int          fd;
        int          lineCount;
        int          fieldCount;
        string       line;
        logic [31:0] fInstr;
        logic [3:0]  fIrq;
        logic [3:0]  fPc31;
        logic [23:0] fCtrl;
        vector_t     v;
        fd = $fopen("sim/controlGolden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file sim/controlGolden.txt");
            errorCount++;
            return;
        end
        lineCount = 0;
        while (!$feof(fd) && lineCount < MAX_LINES) begin
            lineCount++;
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "\n" || line[0] == "\r") begin
                if (vectors.size() > 0) begin
                    vectors[vectors.size() - 1].groupEnd = 1'b1;  // group boundary
                end
                continue;
            end
            fieldCount = $sscanf(line, "%h %h %h %h", fInstr, fIrq, fPc31, fCtrl);
            if (fieldCount != 4) begin
                $display("line %0d of the vector file is malformed", lineCount);
                errorCount++;
                continue;
            end
            v.instr    = fInstr;
            v.irq      = fIrq[0];
            v.pc31     = fPc31[0];
            v.expCtrl  = fCtrl[20:0];
            v.groupEnd = 1'b0;
            vectors.push_back(v);
        end
        if (lineCount >= MAX_LINES && !$feof(fd)) begin
            $display("vector file is longer than %0d lines, reading stopped", MAX_LINES);
            errorCount++;
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("vector file holds no vectors");
            errorCount++;
        end else begin
            vectors[vectors.size() - 1].groupEnd = 1'b1;
        end
    endtask

    task automatic resetPhase();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) begin
                rst <= 1'b0;                 // this edge still sees rst high
            end
            @(negedge clk);
            assert (ctrl === ctrlPkg::CTRL_BUBBLE) else begin
                errorCount++;
                $display("Error ctrl expected %h got %h in reset cycle %0d",
                         ctrlPkg::CTRL_BUBBLE, ctrl, i);
            end
        end
    endtask

    task automatic checkCtrl(input vector_t v, input int idx);
        assert (ctrl === v.expCtrl) else begin
            errorCount++;
            $display("Error ctrl expected %h got %h at vector %0d (instr %h irq %h pc31 %h)",
                     v.expCtrl, ctrl, idx, v.instr, v.irq, v.pc31);
        end
    endtask

    // drive on the rising edge, check the previous slot at the falling edge
    task automatic stepCycle(input logic drive, input vector_t v, input int idx);
        @(posedge clk);
        if (drive) begin
            instr <= v.instr;
            irq   <= v.irq;
            pc31  <= v.pc31;
        end else begin
            instr <= '0;                     // nop while idle
            irq   <= 1'b0;
            pc31  <= 1'b0;
        end
        @(negedge clk);
        if (pendValid) begin
            checkCtrl(pending, pendIdx);
        end
        pendValid = drive;
        pending   = v;
        pendIdx   = idx;
    endtask

    task automatic runVectors();
        int gap;
        for (int i = 0; i < vectors.size(); i++) begin
            stepCycle(1'b1, vectors[i], i);
            if (vectors[i].groupEnd) begin
                gap = $urandom_range(MAX_GAP, 0);
                for (int g = 0; g < gap; g++) begin
                    stepCycle(1'b0, '0, -1);
                end
            end
        end
        stepCycle(1'b0, '0, -1);             // drains the last slot
    endtask

    task automatic finishRun();
        int total;
        total = errorCount + DUT.checks.failCount;
        $display("errors: %0d (testbench checks %0d, assertions %0d)",
                 total, errorCount, DUT.checks.failCount);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'hab4b));
        rst        = 1'b1;
        instr      = '0;
        irq        = 1'b0;
        pc31       = 1'b0;
        errorCount = 0;
        pendValid  = 1'b0;
        pending    = '0;
        pendIdx    = 0;
        loadVectors();
        resetPhase();
        if (vectors.size() > 0) begin
            runVectors();
        end
        finishRun();
    end

endmodule

// File: sim/controlGolden.txt
# columns: instr irq pc31 expected-ctrl, all hex; ctrl is the 21-bit word one cycle later
# a blank line closes a group of back-to-back vectors, idle cycles may follow it
00221820 0 0 008040
00221821 0 0 008000
00221822 0 0 0080c0
00221823 0 0 008080
00221824 0 0 008c00
00221825 0 0 008f00
00221826 0 0 008b00
00221827 0 0 008880
00021900 0 0 00d000
00021902 0 0 00d080
00021903 0 0 00d180
0022182a 0 0 009ac0
03e00008 0 0 0c0000
00a0f809 0 0 0c8008

8c220004 0 0 01a016
ac220008 0 0 002022
3c021234 0 0 01a001
2022ffff 0 0 01a042
24220010 0 0 01a002
302200ff 0 0 01ac00
2822fff0 0 0 01bac2
2c220005 0 0 01ba82
10220003 0 0 041982
1422fffd 0 0 041882
18200002 0 0 041e82
1c200002 0 0 041f82
04200002 0 0 041d82
08000040 0 0 080000
0c000040 0 0 0a8008

00221820 1 0 13800c
8c220004 1 0 13800c
fc000000 1 0 13800c
fc000000 0 0 178008
80220000 0 0 178008
0000003f 0 0 178008
00221805 0 0 178008

00221820 1 1 008040
8c220004 1 1 01a016
fc000000 0 1 000000
0000003f 1 1 000000
0c000040 0 1 0a8008
03e00008 1 0 13800c

// File: files.f
logic/ctrlPkg.sv
logic/functDecoder.sv
logic/opcodeDecoder.sv
logic/trapArbiter.sv
logic/controlUnit.sv
sim/controlUnit_assertions.sv
sim/controlUnitTb.sv
